// ==== design/vp_cfg_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// System package for the Videopac I/O block
// TV standards, enable divisors, download indices, cartridge sizes
// and the special key codes of the console keyboard
//////////////////////////////////////////////////////////////////////

package vp_cfg_pkg;

	// TV standard select
	typedef enum logic {
		TV_NTSC = 1'b0,
		TV_PAL  = 1'b1
	} tv_std_t;

	// System clocks per enable pulse
	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int VDC_DIV_NTSC = 6;
	localparam int VDC_DIV_PAL  = 10;
	localparam int DIV_W        = 4;

	// Download index codes, below CHAR goes to program ROM
	localparam int LOAD_IDX_CART = 1;
	localparam int LOAD_IDX_XROM = 2;
	localparam int LOAD_IDX_CHAR = 3;

	// Cartridge sizes in words
	localparam int SIZE_4K  = 4096;
	localparam int SIZE_8K  = 8192;
	localparam int SIZE_16K = 16384;
	localparam int SIZE_W   = 16;

	// Memory address widths
	localparam int ROM_AW  = 14;
	localparam int CHAR_AW = 9;

	// Special key codes, zero means no key
	localparam logic [7:0] KEY_YES   = 8'h11;
	localparam logic [7:0] KEY_NO    = 8'h12;
	localparam logic [7:0] KEY_ENTER = 8'd10;
	localparam logic [7:0] KEY_BKSP  = 8'd8;

endpackage

// ==== design/vp_video_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Video package for the Videopac I/O block
// Colour index and RGB types, both palettes, greyscale weights
//////////////////////////////////////////////////////////////////////

package vp_video_pkg;

	// Field order is the palette index, red is the MSB
	typedef struct packed {
		logic red;
		logic green;
		logic blue;
		logic luma;
	} color_idx_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Calibrated RF palette
	localparam rgb_t PAL_TV [16] = '{
		24'h000000, 24'h676767,
		24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151,
		24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a,
		24'hcecece, 24'hffffff
	};

	// Pure RGB palette, luma lifts each channel
	localparam rgb_t PAL_RGB [16] = '{
		24'h000000, 24'h494949,
		24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949,
		24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49,
		24'hb6b6b6, 24'hffffff
	};

	// Luma weights, sum is 256
	localparam int GREY_WR = 77;
	localparam int GREY_WG = 150;
	localparam int GREY_WB = 29;

endpackage

// ==== design/vp_clock_enables.sv ====
//////////////////////////////////////////////////////////////////////
// CPU and video chip clock enable pulse generator
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module vp_clock_enables (
	input  logic                clk_sys,
	input  logic                reset,
	input  vp_cfg_pkg::tv_std_t tv_std_i,
	output logic                cpu_en_o,
	output logic                vdc_en_o
);
	import vp_cfg_pkg::*;

	logic [DIV_W-1:0] cpu_ctr;
	logic [DIV_W-1:0] vdc_ctr;
	logic [DIV_W-1:0] cpu_last;
	logic [DIV_W-1:0] vdc_last;
	tv_std_t          tv_std_q;
	logic             std_change;

	// Terminal counts per standard
	assign cpu_last = (tv_std_i == TV_PAL) ? DIV_W'(CPU_DIV_PAL - 1) : DIV_W'(CPU_DIV_NTSC - 1);
	assign vdc_last = (tv_std_i == TV_PAL) ? DIV_W'(VDC_DIV_PAL - 1) : DIV_W'(VDC_DIV_NTSC - 1);

	// Tracks the standard through reset as well
	always_ff @(posedge clk_sys) begin
		tv_std_q <= tv_std_i;
	end
	assign std_change = (tv_std_q != tv_std_i);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_ctr  <= '0;
			vdc_ctr  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else if (std_change) begin
			// Standard switch, both dividers restart
			cpu_ctr  <= '0;
			vdc_ctr  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			cpu_en_o <= (cpu_ctr >= cpu_last);
			cpu_ctr  <= (cpu_ctr >= cpu_last) ? '0 : cpu_ctr + 1'b1;
			vdc_en_o <= (vdc_ctr >= vdc_last);
			vdc_ctr  <= (vdc_ctr >= vdc_last) ? '0 : vdc_ctr + 1'b1;
		end
	end

	// Single-cycle pulses only
	a_cpu_pulse: assert property (@(posedge clk_sys) disable iff (reset) cpu_en_o |=> !cpu_en_o);
	a_vdc_pulse: assert property (@(posedge clk_sys) disable iff (reset) vdc_en_o |=> !vdc_en_o);

endmodule

// ==== design/vp_cart_loader.sv ====
//////////////////////////////////////////////////////////////////////
// Cartridge and XROM download tracking with size counter
// Program and character ROM write steering, bank address map
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module vp_cart_loader #(
	parameter int ROM_AW = vp_cfg_pkg::ROM_AW
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	// Load side
	input  logic                           dl_i,
	input  logic                           dl_wr_i,
	input  logic [7:0]                     dl_index_i,
	input  logic [15:0]                    dl_addr_i,
	// Console side
	input  logic [11:0]                    cart_addr_i,
	input  logic                           bank0_i,
	input  logic                           bank1_i,
	input  logic                           cart_rd_n_i,
	input  logic                           cart_cs_n_i,
	input  logic [vp_cfg_pkg::CHAR_AW-1:0] char_addr_i,
	// Memory controls
	output logic [ROM_AW-1:0]              rom_addr_o,
	output logic                           rom_we_o,
	output logic                           rom_rd_o,
	output logic [vp_cfg_pkg::CHAR_AW-1:0] char_addr_o,
	output logic                           char_we_o
);
	import vp_cfg_pkg::*;

	logic              dl_q;
	logic              xrom;
	logic [SIZE_W-1:0] cart_size;
	logic              prog_sel;
	logic              char_sel;
	logic [ROM_AW-1:0] map_addr;

	assign prog_sel = (dl_index_i < 8'(LOAD_IDX_CHAR));
	assign char_sel = (dl_index_i == 8'(LOAD_IDX_CHAR));

	// Download start clears the size, every write counts
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_q      <= 1'b0;
			xrom      <= 1'b0;
			cart_size <= '0;
		end else begin
			dl_q <= dl_i;
			if (dl_i && !dl_q) begin
				cart_size <= '0;
				xrom      <= (dl_index_i == 8'(LOAD_IDX_XROM));
			end else if (dl_i && dl_wr_i) begin
				cart_size <= cart_size + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Bank mapping by loaded size
	////////////////////////////////////////////////////////////////////

	always_comb begin
		if (xrom) begin
			map_addr = ROM_AW'(cart_addr_i);
		end else begin
			case (cart_size)
				SIZE_W'(SIZE_4K):  map_addr = ROM_AW'({bank0_i, cart_addr_i[11], cart_addr_i[9:0]});
				SIZE_W'(SIZE_8K):  map_addr = ROM_AW'({bank1_i, bank0_i, cart_addr_i[11],
						cart_addr_i[9:0]});
				SIZE_W'(SIZE_16K): map_addr = ROM_AW'({bank1_i, bank0_i, cart_addr_i});
				// 2K and odd sizes, bit 10 unused
				default:           map_addr = ROM_AW'({cart_addr_i[11], cart_addr_i[9:0]});
			endcase
		end
	end

	// Load address wins during a program download
	assign rom_addr_o = (dl_i && prog_sel) ? dl_addr_i[ROM_AW-1:0] : map_addr;
	assign rom_we_o   = dl_wr_i && prog_sel;

	// XROM sits outside the bank0 window of the chip select
	assign rom_rd_o = xrom ? (cart_rd_n_i & ~(cart_cs_n_i & bank0_i)) : ~cart_rd_n_i;

	// Font download
	assign char_addr_o = (dl_i && char_sel) ? dl_addr_i[CHAR_AW-1:0] : char_addr_i;
	assign char_we_o   = dl_wr_i && char_sel;

	a_one_rom_we: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_we_o && char_we_o));

endmodule

// ==== design/vp_ps2_decode.sv ====
//////////////////////////////////////////////////////////////////////
// PS/2 key strobe detection and scan code to ASCII table
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module vp_ps2_decode (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key_i,
	output logic        ps2_changed_o,
	output logic [7:0]  ps2_ascii_o,
	output logic        ps2_released_o
);
	import vp_cfg_pkg::*;

	logic strobe_q;
	logic toggle;

	// Set-2 scan codes, extended bit ignored
	function automatic logic [7:0] scan_to_ascii(input logic [7:0] sc);
		logic [7:0] code;
		case (sc)
			8'h16: code = "1";
			8'h1e: code = "2";
			8'h26: code = "3";
			8'h25: code = "4";
			8'h2e: code = "5";
			8'h36: code = "6";
			8'h3d: code = "7";
			8'h3e: code = "8";
			8'h46: code = "9";
			8'h45: code = "0";
			8'h1c: code = "a";
			8'h32: code = "b";
			8'h21: code = "c";
			8'h23: code = "d";
			8'h24: code = "e";
			8'h2b: code = "f";
			8'h34: code = "g";
			8'h33: code = "h";
			8'h43: code = "i";
			8'h3b: code = "j";
			8'h42: code = "k";
			8'h4b: code = "l";
			8'h3a: code = "m";
			8'h31: code = "n";
			8'h44: code = "o";
			8'h4d: code = "p";
			8'h15: code = "q";
			8'h2d: code = "r";
			8'h1b: code = "s";
			8'h2c: code = "t";
			8'h3c: code = "u";
			8'h2a: code = "v";
			8'h1d: code = "w";
			8'h22: code = "x";
			8'h35: code = "y";
			8'h1a: code = "z";
			8'h29: code = " ";
			// Keypad and main row symbols
			8'h79: code = "+";
			8'h7b: code = "-";
			8'h7c: code = "*";
			8'h4a: code = "/";
			8'h55: code = "=";
			// GUI keys answer yes/no prompts
			8'h1f: code = KEY_YES;
			8'h27: code = KEY_NO;
			8'h5a: code = KEY_ENTER;
			8'h66: code = KEY_BKSP;
			default: code = 8'h00;
		endcase
		return code;
	endfunction

	// Bit 10 flips once per key event
	assign toggle = (strobe_q != ps2_key_i[10]);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			strobe_q       <= 1'b0;
			ps2_changed_o  <= 1'b0;
			ps2_ascii_o    <= 8'h00;
			ps2_released_o <= 1'b1;
		end else begin
			strobe_q       <= ps2_key_i[10];
			ps2_changed_o  <= toggle;
			// Bit 9 set means pressed
			ps2_released_o <= ~ps2_key_i[9];
			if (toggle) begin
				ps2_ascii_o <= scan_to_ascii(ps2_key_i[7:0]);
			end
		end
	end

endmodule

// ==== design/vp_joy_input.sv ====
//////////////////////////////////////////////////////////////////////
// Joystick numpad events merged with PS/2 key events
// Active-low direction, action and reset outputs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module vp_joy_input (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] joy_a_i,
	input  logic [15:0] joy_b_i,
	input  logic        swap_i,
	input  logic        ps2_changed_i,
	input  logic [7:0]  ps2_ascii_i,
	input  logic        ps2_released_i,
	output logic        key_ready_o,
	output logic [7:0]  key_ascii_o,
	output logic        key_released_o,
	output logic [1:0]  joy_up_n_o,
	output logic [1:0]  joy_down_n_o,
	output logic [1:0]  joy_left_n_o,
	output logic [1:0]  joy_right_n_o,
	output logic [1:0]  joy_action_n_o,
	output logic        joy_reset_n_o
);
	logic [15:0] pad_p1;
	logic [15:0] pad_p2;
	logic [9:0]  numpad;
	logic [9:0]  numpad_q;
	logic [9:0]  joy_changed;
	logic        joy_released;
	logic [7:0]  joy_ascii;

	// Lowest set bit wins, bit 9 is digit zero
	function automatic logic [7:0] pad_digit(input logic [9:0] pad);
		logic [7:0] code;
		code = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i]) begin
				code = (i == 9) ? "0" : 8'("1" + i);
			end
		end
		return code;
	endfunction

	// Either pad may type digits
	assign numpad = joy_a_i[15:6] | joy_b_i[15:6];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			numpad_q     <= '0;
			joy_changed  <= '0;
			joy_released <= 1'b1;
			joy_ascii    <= 8'h00;
		end else begin
			numpad_q     <= numpad;
			joy_changed  <= numpad ^ numpad_q;
			joy_released <= (numpad == '0);
			// Last digit held until the next press
			if (numpad != '0) begin
				joy_ascii <= pad_digit(numpad);
			end
		end
	end

	// Key event merge, PS/2 has priority
	assign key_ready_o    = ps2_changed_i | (|joy_changed);
	assign key_ascii_o    = ps2_changed_i ? ps2_ascii_i : joy_ascii;
	assign key_released_o = ps2_released_i & joy_released;

	////////////////////////////////////////////////////////////////////
	// Pad outputs, player one in the upper bit
	////////////////////////////////////////////////////////////////////

	assign pad_p1 = swap_i ? joy_b_i : joy_a_i;
	assign pad_p2 = swap_i ? joy_a_i : joy_b_i;

	assign joy_up_n_o     = {~pad_p1[3], ~pad_p2[3]};
	assign joy_down_n_o   = {~pad_p1[2], ~pad_p2[2]};
	assign joy_left_n_o   = {~pad_p1[1], ~pad_p2[1]};
	assign joy_right_n_o  = {~pad_p1[0], ~pad_p2[0]};
	assign joy_action_n_o = {~pad_p1[4], ~pad_p2[4]};
	assign joy_reset_n_o  = ~joy_a_i[5] & ~joy_b_i[5];

endmodule

// ==== design/vp_color_out.sv ====
//////////////////////////////////////////////////////////////////////
// Colour index to RGB through palette lookup
// Optional greyscale TV, one register stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module vp_color_out (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  vp_video_pkg::color_idx_t color_i,
	input  logic                     rgb_pal_i,
	input  logic                     mono_i,
	output vp_video_pkg::rgb_t       rgb_o
);
	import vp_video_pkg::*;

	logic [3:0]  pal_idx;
	rgb_t        entry;
	logic [15:0] grey_sum;
	logic [7:0]  grey;
	rgb_t        rgb_next;

	// Struct bits form the index directly
	assign pal_idx = color_i;
	assign entry   = rgb_pal_i ? PAL_RGB[pal_idx] : PAL_TV[pal_idx];

	// Weighted luma, weights sum to 256
	assign grey_sum = 16'(GREY_WR * entry.red + GREY_WG * entry.green + GREY_WB * entry.blue);
	assign grey     = grey_sum[15:8];

	always_comb begin
		if (mono_i) begin
			rgb_next = '{red: grey, green: grey, blue: grey};
		end else begin
			rgb_next = entry;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else begin
			rgb_o <= rgb_next;
		end
	end

endmodule

// ==== design/vp_io_top.sv ====
//////////////////////////////////////////////////////////////////////
// Videopac I/O glue top level
// Clock enables, cartridge loader, keyboard, joysticks, colour
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module vp_io_top #(
	parameter int ROM_AW = vp_cfg_pkg::ROM_AW
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	// Clock enables
	input  vp_cfg_pkg::tv_std_t            tv_std_i,
	output logic                           cpu_en_o,
	output logic                           vdc_en_o,
	// Download and cartridge bus
	input  logic                           dl_i,
	input  logic                           dl_wr_i,
	input  logic [7:0]                     dl_index_i,
	input  logic [15:0]                    dl_addr_i,
	input  logic [11:0]                    cart_addr_i,
	input  logic                           bank0_i,
	input  logic                           bank1_i,
	input  logic                           cart_rd_n_i,
	input  logic                           cart_cs_n_i,
	input  logic [vp_cfg_pkg::CHAR_AW-1:0] char_addr_i,
	output logic [ROM_AW-1:0]              rom_addr_o,
	output logic                           rom_we_o,
	output logic                           rom_rd_o,
	output logic [vp_cfg_pkg::CHAR_AW-1:0] char_addr_o,
	output logic                           char_we_o,
	// Keyboard and joysticks
	input  logic [10:0]                    ps2_key_i,
	input  logic [15:0]                    joy_a_i,
	input  logic [15:0]                    joy_b_i,
	input  logic                           swap_i,
	output logic                           key_ready_o,
	output logic [7:0]                     key_ascii_o,
	output logic                           key_released_o,
	output logic [1:0]                     joy_up_n_o,
	output logic [1:0]                     joy_down_n_o,
	output logic [1:0]                     joy_left_n_o,
	output logic [1:0]                     joy_right_n_o,
	output logic [1:0]                     joy_action_n_o,
	output logic                           joy_reset_n_o,
	// Colour, index order red green blue luma
	input  logic [3:0]                     color_i,
	input  logic                           rgb_pal_i,
	input  logic                           mono_i,
	output logic [7:0]                     rgb_r_o,
	output logic [7:0]                     rgb_g_o,
	output logic [7:0]                     rgb_b_o
);
	import vp_video_pkg::*;

	logic       ps2_changed;
	logic [7:0] ps2_ascii;
	logic       ps2_released;
	color_idx_t color_s;
	rgb_t       rgb_s;

	assign color_s = color_i;
	assign rgb_r_o = rgb_s.red;
	assign rgb_g_o = rgb_s.green;
	assign rgb_b_o = rgb_s.blue;

	vp_clock_enables u_clk_en (
		.clk_sys(clk_sys), .reset(reset), .tv_std_i(tv_std_i),
		.cpu_en_o(cpu_en_o), .vdc_en_o(vdc_en_o)
	);

	vp_cart_loader #(.ROM_AW(ROM_AW)) u_cart (
		.clk_sys(clk_sys), .reset(reset),
		.dl_i(dl_i), .dl_wr_i(dl_wr_i), .dl_index_i(dl_index_i), .dl_addr_i(dl_addr_i),
		.cart_addr_i(cart_addr_i), .bank0_i(bank0_i), .bank1_i(bank1_i),
		.cart_rd_n_i(cart_rd_n_i), .cart_cs_n_i(cart_cs_n_i), .char_addr_i(char_addr_i),
		.rom_addr_o(rom_addr_o), .rom_we_o(rom_we_o), .rom_rd_o(rom_rd_o),
		.char_addr_o(char_addr_o), .char_we_o(char_we_o)
	);

	vp_ps2_decode u_ps2 (
		.clk_sys(clk_sys), .reset(reset), .ps2_key_i(ps2_key_i),
		.ps2_changed_o(ps2_changed), .ps2_ascii_o(ps2_ascii), .ps2_released_o(ps2_released)
	);

	vp_joy_input u_joy (
		.clk_sys(clk_sys), .reset(reset),
		.joy_a_i(joy_a_i), .joy_b_i(joy_b_i), .swap_i(swap_i),
		.ps2_changed_i(ps2_changed), .ps2_ascii_i(ps2_ascii), .ps2_released_i(ps2_released),
		.key_ready_o(key_ready_o), .key_ascii_o(key_ascii_o), .key_released_o(key_released_o),
		.joy_up_n_o(joy_up_n_o), .joy_down_n_o(joy_down_n_o),
		.joy_left_n_o(joy_left_n_o), .joy_right_n_o(joy_right_n_o),
		.joy_action_n_o(joy_action_n_o), .joy_reset_n_o(joy_reset_n_o)
	);

	vp_color_out u_color (
		.clk_sys(clk_sys), .reset(reset), .color_i(color_s),
		.rgb_pal_i(rgb_pal_i), .mono_i(mono_i), .rgb_o(rgb_s)
	);

endmodule

// ==== bench/tb_vp_io.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the Videopac I/O block
// Stimulus tasks, reference functions, per-cycle checker, summary
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_vp_io;
	import vp_cfg_pkg::*;
	import vp_video_pkg::*;

	localparam int PERIOD = 40;

	// DUT ports
	logic               clk_sys, reset;
	tv_std_t            tv_std_i;
	logic               cpu_en_o, vdc_en_o;
	logic               dl_i, dl_wr_i;
	logic [7:0]         dl_index_i;
	logic [15:0]        dl_addr_i;
	logic [11:0]        cart_addr_i;
	logic               bank0_i, bank1_i, cart_rd_n_i, cart_cs_n_i;
	logic [CHAR_AW-1:0] char_addr_i, char_addr_o;
	logic [ROM_AW-1:0]  rom_addr_o;
	logic               rom_we_o, rom_rd_o, char_we_o;
	logic [10:0]        ps2_key_i;
	logic [15:0]        joy_a_i, joy_b_i;
	logic               swap_i;
	logic               key_ready_o, key_released_o;
	logic [7:0]         key_ascii_o;
	logic [1:0]         joy_up_n_o, joy_down_n_o, joy_left_n_o, joy_right_n_o;
	logic [1:0]         joy_action_n_o;
	logic               joy_reset_n_o;
	logic [3:0]         color_i;
	logic               rgb_pal_i, mono_i;
	logic [7:0]         rgb_r_o, rgb_g_o, rgb_b_o;

	// Bookkeeping
	string      test_name;
	integer     seed = 5190;
	int         test_errors, total_errors, tests_run;
	int         cpu_pulses, vdc_pulses;
	logic [7:0] ascii_ref [256];
	logic [7:0] known_sc [$];

	// Reference state, advanced once per rising edge
	logic       dl_prev, xrom_m, strobe_m, ps2_chg_m, ps2_rel_m, joy_rel_m;
	int         size_m, cpu_gap, vdc_gap;
	logic [7:0] ps2_ascii_m, joy_ascii_m;
	logic [9:0] numpad_prev, numpad_chg_m;
	tv_std_t    std_prev;
	logic       cpu_seen, vdc_seen;

	// Set-2 scan codes of digits 0 to 9 and letters a to z
	localparam logic [7:0] DIGIT_SC [10] = '{8'h45, 8'h16, 8'h1e, 8'h26, 8'h25,
		8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46};
	localparam logic [7:0] LETTER_SC [26] = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b,
		8'h34, 8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15,
		8'h2d, 8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};

	vp_io_top #(.ROM_AW(ROM_AW)) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference functions
	//////////////////////////////////////////////////////////////////////

	// Cartridge window by loaded size
	function automatic logic [ROM_AW-1:0] ref_rom_addr(input int size, input logic xrom,
			input logic [11:0] a, input logic b0, input logic b1);
		int lo;
		lo = a[11] * 1024 + a[9:0];
		if (xrom)
			return ROM_AW'(a);
		case (size)
			SIZE_4K:  return ROM_AW'(b0 * 2048 + lo);
			SIZE_8K:  return ROM_AW'(b1 * 4096 + b0 * 2048 + lo);
			SIZE_16K: return ROM_AW'(b1 * 8192 + b0 * 4096 + a);
			default:  return ROM_AW'(lo);
		endcase
	endfunction

	// Lowest pressed bit, the tenth key is zero
	function automatic logic [7:0] ref_pad_digit(input logic [9:0] pad);
		for (int i = 0; i < 10; i++) begin
			if (pad[i])
				return 8'("0" + (i + 1) % 10);
		end
		return 8'h00;
	endfunction

	// Up, down, left, right, action pairs, player one high
	function automatic logic [9:0] ref_dirs(input logic [15:0] a, input logic [15:0] b,
			input logic swap);
		logic [15:0] p1, p2;
		p1 = swap ? b : a;
		p2 = swap ? a : b;
		return ~{p1[3], p2[3], p1[2], p2[2], p1[1], p2[1], p1[0], p2[0], p1[4], p2[4]};
	endfunction

	function automatic logic [23:0] ref_color(input logic [3:0] idx, input logic pal,
			input logic mono);
		rgb_t e;
		int   g;
		e = pal ? PAL_RGB[idx] : PAL_TV[idx];
		if (!mono)
			return e;
		g = (GREY_WR * e.red + GREY_WG * e.green + GREY_WB * e.blue) / 256;
		return {3{8'(g)}};
	endfunction

	task automatic add_key(input logic [7:0] sc, input logic [7:0] code);
		ascii_ref[sc] = code;
		known_sc.push_back(sc);
	endtask

	task automatic build_key_table();
		for (int i = 0; i < 256; i++)
			ascii_ref[i] = 8'h00;
		for (int i = 0; i < 10; i++)
			add_key(DIGIT_SC[i], 8'("0" + i));
		for (int i = 0; i < 26; i++)
			add_key(LETTER_SC[i], 8'("a" + i));
		add_key(8'h29, " ");
		add_key(8'h79, "+");
		add_key(8'h7b, "-");
		add_key(8'h7c, "*");
		add_key(8'h4a, "/");
		add_key(8'h55, "=");
		add_key(8'h1f, KEY_YES);
		add_key(8'h27, KEY_NO);
		add_key(8'h5a, KEY_ENTER);
		add_key(8'h66, KEY_BKSP);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checker, samples a quarter period after each rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
		test_errors++;
	endtask

	task automatic advance_model();
		logic [9:0] numpad;
		numpad = joy_a_i[15:6] | joy_b_i[15:6];
		// Download start wins over a write
		if (dl_i && !dl_prev) begin
			size_m = 0;
			xrom_m = (dl_index_i == LOAD_IDX_XROM);
		end else if (dl_i && dl_wr_i) begin
			size_m++;
		end
		dl_prev = dl_i;
		// Extended bit 8 plays no part
		ps2_chg_m = (ps2_key_i[10] != strobe_m);
		if (ps2_chg_m)
			ps2_ascii_m = ascii_ref[ps2_key_i[7:0]];
		strobe_m = ps2_key_i[10];
		ps2_rel_m = !ps2_key_i[9];
		numpad_chg_m = numpad ^ numpad_prev;
		numpad_prev = numpad;
		joy_rel_m = (numpad == '0);
		if (numpad != '0)
			joy_ascii_m = ref_pad_digit(numpad);
	endtask

	task automatic track_enables();
		int cpu_div, vdc_div;
		cpu_div = (tv_std_i == TV_PAL) ? CPU_DIV_PAL : CPU_DIV_NTSC;
		vdc_div = (tv_std_i == TV_PAL) ? VDC_DIV_PAL : VDC_DIV_NTSC;
		// New standard, first gap not measured
		if (tv_std_i != std_prev) begin
			cpu_seen = 1'b0;
			vdc_seen = 1'b0;
		end
		std_prev = tv_std_i;
		cpu_gap++;
		vdc_gap++;
		if (cpu_en_o) begin
			if (cpu_seen && cpu_gap != cpu_div)
				report_mismatch("cpu_en_o gap", cpu_div, cpu_gap);
			cpu_gap = 0;
			cpu_seen = 1'b1;
			cpu_pulses++;
		end
		if (vdc_en_o) begin
			if (vdc_seen && vdc_gap != vdc_div)
				report_mismatch("vdc_en_o gap", vdc_div, vdc_gap);
			vdc_gap = 0;
			vdc_seen = 1'b1;
			vdc_pulses++;
		end
	endtask

	task automatic compare_outputs();
		logic [ROM_AW-1:0] exp_addr;
		logic              prog, font;
		prog = dl_i && (dl_index_i < LOAD_IDX_CHAR);
		font = dl_i && (dl_index_i == LOAD_IDX_CHAR);
		exp_addr = prog ? dl_addr_i[ROM_AW-1:0]
			: ref_rom_addr(size_m, xrom_m, cart_addr_i, bank0_i, bank1_i);
		if (rom_addr_o !== exp_addr)
			report_mismatch("rom_addr_o", exp_addr, rom_addr_o);
		if (rom_we_o !== (prog && dl_wr_i))
			report_mismatch("rom_we_o", prog && dl_wr_i, rom_we_o);
		if (rom_rd_o !== (xrom_m ? (cart_rd_n_i && !(cart_cs_n_i && bank0_i)) : !cart_rd_n_i))
			report_mismatch("rom_rd_o", !rom_rd_o, rom_rd_o);
		if (char_we_o !== (font && dl_wr_i))
			report_mismatch("char_we_o", font && dl_wr_i, char_we_o);
		if (char_addr_o !== (font ? dl_addr_i[CHAR_AW-1:0] : char_addr_i))
			report_mismatch("char_addr_o", font ? dl_addr_i[CHAR_AW-1:0] : char_addr_i,
				char_addr_o);
		if (key_ready_o !== (ps2_chg_m || (|numpad_chg_m)))
			report_mismatch("key_ready_o", !key_ready_o, key_ready_o);
		if (key_ascii_o !== (ps2_chg_m ? ps2_ascii_m : joy_ascii_m))
			report_mismatch("key_ascii_o", ps2_chg_m ? ps2_ascii_m : joy_ascii_m, key_ascii_o);
		if (key_released_o !== (ps2_rel_m && joy_rel_m))
			report_mismatch("key_released_o", ps2_rel_m && joy_rel_m, key_released_o);
		if ({joy_up_n_o, joy_down_n_o, joy_left_n_o, joy_right_n_o, joy_action_n_o}
				!== ref_dirs(joy_a_i, joy_b_i, swap_i))
			report_mismatch("joystick pairs", ref_dirs(joy_a_i, joy_b_i, swap_i),
				{joy_up_n_o, joy_down_n_o, joy_left_n_o, joy_right_n_o, joy_action_n_o});
		if (joy_reset_n_o !== !(joy_a_i[5] || joy_b_i[5]))
			report_mismatch("joy_reset_n_o", !joy_reset_n_o, joy_reset_n_o);
		// Inputs are still those registered at this edge
		if ({rgb_r_o, rgb_g_o, rgb_b_o} !== ref_color(color_i, rgb_pal_i, mono_i))
			report_mismatch("rgb_o", ref_color(color_i, rgb_pal_i, mono_i),
				{rgb_r_o, rgb_g_o, rgb_b_o});
	endtask

	always @(posedge clk_sys) begin
		#(PERIOD / 4);
		if (reset) begin
			dl_prev = 1'b0;
			xrom_m = 1'b0;
			size_m = 0;
			strobe_m = 1'b0;
			ps2_chg_m = 1'b0;
			ps2_ascii_m = 8'h00;
			ps2_rel_m = 1'b1;
			numpad_prev = '0;
			numpad_chg_m = '0;
			joy_rel_m = 1'b1;
			joy_ascii_m = 8'h00;
			std_prev = tv_std_i;
			cpu_seen = 1'b0;
			vdc_seen = 1'b0;
		end else begin
			advance_model();
			track_enables();
			compare_outputs();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus, every task starts and ends on a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(negedge clk_sys);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		// Let the checker see the last inputs
		next_cycle();
		next_cycle();
		tests_run++;
		total_errors += test_errors;
		$display("%s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
			test_errors);
	endtask

	task automatic run_enables(input tv_std_t std);
		int waited;
		tv_std_i = std;
		cpu_pulses = 0;
		vdc_pulses = 0;
		waited = 0;
		while ((cpu_pulses < 5 || vdc_pulses < 5) && waited < 200) begin
			next_cycle();
			waited++;
		end
		if (cpu_pulses < 5 || vdc_pulses < 5) begin
			$display("[ERROR] %s: enable pulses stopped coming", test_name);
			test_errors++;
		end
	endtask

	// One idle cycle with the level high, then the writes
	task automatic download(input int index, input int words);
		dl_index_i = 8'(index);
		dl_i = 1'b1;
		next_cycle();
		for (int i = 0; i < words; i++) begin
			dl_wr_i = 1'b1;
			dl_addr_i = 16'(i);
			next_cycle();
		end
		dl_wr_i = 1'b0;
		dl_i = 1'b0;
		next_cycle();
	endtask

	task automatic cart_reads(input int count);
		for (int i = 0; i < count; i++) begin
			cart_addr_i = 12'($random(seed));
			bank0_i = 1'($random(seed));
			bank1_i = 1'($random(seed));
			cart_rd_n_i = 1'($random(seed));
			cart_cs_n_i = 1'($random(seed));
			char_addr_i = CHAR_AW'($random(seed));
			next_cycle();
		end
	endtask

	// Toggle the strobe bit, then wait for the key event
	task automatic send_ps2(input logic [7:0] sc);
		int waited;
		ps2_key_i = {~ps2_key_i[10], 1'($random(seed)), 1'($random(seed)), sc};
		next_cycle();
		waited = 0;
		while (!key_ready_o && waited < 8) begin
			next_cycle();
			waited++;
		end
		if (!key_ready_o) begin
			$display("[ERROR] %s: no key_ready_o pulse after the PS/2 strobe toggle", test_name);
			test_errors++;
		end
		next_cycle();
	endtask

	initial begin
		reset = 1'b1;
		tv_std_i = TV_NTSC;
		{dl_i, dl_wr_i, dl_index_i, dl_addr_i} = '0;
		{cart_addr_i, bank0_i, bank1_i, char_addr_i} = '0;
		cart_rd_n_i = 1'b1;
		cart_cs_n_i = 1'b1;
		ps2_key_i = '0;
		{joy_a_i, joy_b_i, swap_i} = '0;
		{color_i, rgb_pal_i, mono_i} = '0;
		{test_errors, total_errors, tests_run} = '0;
		test_name = "reset";
		build_key_table();
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		start_test("clock enables");
		run_enables(TV_PAL);
		run_enables(TV_NTSC);
		end_test();

		start_test("cartridge map");
		download(LOAD_IDX_CART, 2048);
		cart_reads(64);
		download(LOAD_IDX_CART, SIZE_4K);
		cart_reads(64);
		download(LOAD_IDX_CART, SIZE_8K);
		cart_reads(64);
		download(LOAD_IDX_CART, SIZE_16K);
		cart_reads(64);
		end_test();

		start_test("xrom and char rom");
		download(LOAD_IDX_XROM, SIZE_4K);
		cart_reads(128);
		download(LOAD_IDX_CHAR, 1 << CHAR_AW);
		cart_reads(32);
		end_test();

		start_test("ps2 keys");
		for (int i = 0; i < 60; i++)
			send_ps2(known_sc[$unsigned($random(seed)) % known_sc.size()]);
		for (int i = 0; i < 20; i++)
			send_ps2(8'($random(seed)));
		end_test();

		start_test("joysticks");
		for (int i = 0; i < 200; i++) begin
			joy_a_i = 16'($random(seed));
			joy_b_i = 16'($random(seed));
			swap_i = (i >= 100);
			// Every other word releases the numpad
			if (i % 2) begin
				joy_a_i[15:6] = '0;
				joy_b_i[15:6] = '0;
			end
			next_cycle();
		end
		joy_a_i = '0;
		joy_b_i = '0;
		end_test();

		start_test("colour output");
		for (int i = 0; i < 128; i++) begin
			color_i = 4'($random(seed));
			rgb_pal_i = i[5];
			mono_i = i[6];
			next_cycle();
		end
		end_test();

		$display("tests %0d, errors %0d", tests_run, total_errors);
		if (total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== videopac_io.f ====
design/vp_cfg_pkg.sv
design/vp_video_pkg.sv
design/vp_clock_enables.sv
design/vp_cart_loader.sv
design/vp_ps2_decode.sv
design/vp_joy_input.sv
design/vp_color_out.sv
design/vp_io_top.sv
bench/tb_vp_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the Videopac I/O testbench
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vp_io \
	-f videopac_io.f \
	-o tb_vp_io

./obj_dir/tb_vp_io > "$LOG" 2>&1
cat "$LOG"

# The run counts as good only when the bench reported success
if grep -qx "Test passed" "$LOG"; then
	exit 0
fi
exit 1
